/* cache_core.sv */
`timescale 1ns/1ns

module cache_core #(
  parameter int sets_p = 8,
  parameter int ways_p = 2,
  parameter int block_words_p = 4,
  parameter int mem_words_p = 1024
) (
  input  logic clk_i,
  input  logic reset_i,
  input  link_cache_pkg::cache_pkt_s pkt_i,
  input  logic v_i,
  output logic ready_o,
  output logic [link_cache_pkg::data_width_gp-1:0] data_o,
  output logic v_o,
  input  logic yumi_i,
  output logic v_we_o
);

  import link_cache_pkg::*;

  localparam int lg_sets_lp = (sets_p > 1) ? $clog2(sets_p) : 1;
  localparam int lg_ways_lp = (ways_p > 1) ? $clog2(ways_p) : 1;
  localparam int lg_words_lp = (block_words_p > 1) ? $clog2(block_words_p) : 1;
  localparam int block_off_lp = lg_words_lp + 2;
  localparam int tag_width_lp = addr_width_gp + 1 - block_off_lp - lg_sets_lp;
  localparam int lg_mem_lp = $clog2(mem_words_p);

  typedef enum logic [1:0] {S_LOOKUP, S_WB, S_FILL, S_DONE} tv_state_e;

  logic [tag_width_lp-1:0] tag_r [sets_p][ways_p];
  logic [ways_p-1:0] valid_r [sets_p];
  logic [ways_p-1:0] dirty_r [sets_p];
  logic [data_width_gp-1:0] data_r [sets_p][ways_p][block_words_p];
  logic [lg_ways_lp-1:0] rr_r [sets_p];
  logic [data_width_gp-1:0] mem_r [mem_words_p];

  logic live_r, tl_v_r, tv_v_r;
  cache_pkt_s tl_pkt_r, tv_pkt_r;
  tv_state_e state_r;
  logic [lg_words_lp-1:0] fill_cnt_r;
  logic [data_width_gp-1:0] rdata_r;

  logic [lg_sets_lp-1:0] tv_set;
  logic [lg_words_lp-1:0] tv_word;
  logic [1:0] tv_byte;
  logic [tag_width_lp-1:0] tv_tag;
  logic [lg_ways_lp-1:0] tv_way, hit_way, victim, wb_way;
  logic hit, is_data_op, op_fire, go_miss, fill_last, wb_en;
  logic [data_width_gp-1:0] old_word, new_word, result;
  logic [15:0] half;
  logic [7:0] byte_v;

  assign tv_byte = tv_pkt_r.addr[1:0];
  assign tv_word = tv_pkt_r.addr[2 +: lg_words_lp];
  assign tv_set = tv_pkt_r.addr[block_off_lp +: lg_sets_lp];
  assign tv_tag = tv_pkt_r.addr[block_off_lp + lg_sets_lp +: tag_width_lp];
  // tag space puts the way number right above the index
  assign tv_way = tv_pkt_r.addr[block_off_lp + lg_sets_lp +: lg_ways_lp];
  assign victim = rr_r[tv_set];

  assign v_o = tv_v_r && (state_r == S_DONE);
  assign data_o = rdata_r;
  assign v_we_o = tl_v_r & (~tv_v_r | (v_o & yumi_i));
  assign ready_o = live_r & (~tl_v_r | v_we_o);

  always_comb begin
    hit = 1'b0;
    hit_way = '0;
    for (int i = 0; i < ways_p; i++) begin
      if (valid_r[tv_set][i] && tag_r[tv_set][i] == tv_tag) begin
        hit = 1'b1;
        hit_way = lg_ways_lp'(i);
      end
    end
  end

  assign is_data_op = tv_pkt_r.opcode inside {SM, LW, LH, LHU, LB, LBU, AMOSWAP_W, AMOOR_W};
  assign op_fire = tv_v_r && (state_r == S_LOOKUP) && (hit || !is_data_op);
  assign go_miss = tv_v_r && (state_r == S_LOOKUP) && !hit && is_data_op;
  assign fill_last = (fill_cnt_r == lg_words_lp'(block_words_p - 1));

  always_comb begin
    old_word = data_r[tv_set][hit_way][tv_word];
    half = tv_byte[1] ? old_word[31:16] : old_word[15:0];
    byte_v = old_word[8*tv_byte +: 8];
    new_word = old_word;
    result = '0;
    case (tv_pkt_r.opcode)
      LW:  result = old_word;
      LH:  result = {{16{half[15]}}, half};
      LHU: result = {16'b0, half};
      LB:  result = {{24{byte_v[7]}}, byte_v};
      LBU: result = {24'b0, byte_v};
      SM: begin
        for (int b = 0; b < 4; b++) begin
          if (tv_pkt_r.mask[b]) begin
            new_word[8*b +: 8] = tv_pkt_r.data[8*b +: 8];
          end
        end
      end
      AMOSWAP_W: begin
        result = old_word;
        new_word = tv_pkt_r.data;
      end
      AMOOR_W: begin
        result = old_word;
        new_word = old_word | tv_pkt_r.data;
      end
      TAGLA: begin
        result = data_width_gp'(tag_r[tv_set][tv_way]);
        result[31] = valid_r[tv_set][tv_way];
      end
      default: ;
    endcase
  end

  // which block, if any, goes back to memory this cycle
  always_comb begin
    wb_en = 1'b0;
    wb_way = hit_way;
    if (tv_v_r && state_r == S_WB) begin
      wb_en = 1'b1;
      wb_way = victim;
    end else if (op_fire) begin
      case (tv_pkt_r.opcode)
        AFL, AFLINV: wb_en = hit && dirty_r[tv_set][hit_way];
        TAGFL: begin
          wb_en = valid_r[tv_set][tv_way] && dirty_r[tv_set][tv_way];
          wb_way = tv_way;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      // backing store starts out zeroed
      for (int i = 0; i < mem_words_p; i++) begin
        mem_r[i] <= '0;
      end
    end else if (wb_en) begin
      for (int i = 0; i < block_words_p; i++) begin
        mem_r[lg_mem_lp'({tag_r[tv_set][wb_way], tv_set, lg_words_lp'(i)})] <=
          data_r[tv_set][wb_way][i];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (tv_v_r && state_r == S_FILL) begin
      data_r[tv_set][victim][fill_cnt_r] <= mem_r[lg_mem_lp'({tv_tag, tv_set, fill_cnt_r})];
      if (fill_last) begin
        tag_r[tv_set][victim] <= tv_tag;
        valid_r[tv_set][victim] <= 1'b1;
        dirty_r[tv_set][victim] <= 1'b0;
      end
    end
    if (tv_v_r && state_r == S_WB) begin
      dirty_r[tv_set][victim] <= 1'b0;
    end
    if (op_fire) begin
      case (tv_pkt_r.opcode)
        SM, AMOSWAP_W, AMOOR_W: begin
          data_r[tv_set][hit_way][tv_word] <= new_word;
          dirty_r[tv_set][hit_way] <= 1'b1;
        end
        AFL, AFLINV, AINV: begin
          if (hit) begin
            if (tv_pkt_r.opcode != AINV) begin
              dirty_r[tv_set][hit_way] <= 1'b0;
            end
            if (tv_pkt_r.opcode != AFL) begin
              valid_r[tv_set][hit_way] <= 1'b0;
            end
          end
        end
        TAGST: begin
          tag_r[tv_set][tv_way] <= tv_pkt_r.data[tag_width_lp-1:0];
          valid_r[tv_set][tv_way] <= tv_pkt_r.data[31];
          dirty_r[tv_set][tv_way] <= 1'b0;
        end
        TAGFL: dirty_r[tv_set][tv_way] <= 1'b0;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (v_i && ready_o) begin
      tl_pkt_r <= pkt_i;
    end
    if (v_we_o) begin
      tv_pkt_r <= tl_pkt_r;
    end
    if (op_fire) begin
      rdata_r <= result;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      live_r <= 1'b0;
      tl_v_r <= 1'b0;
      tv_v_r <= 1'b0;
      state_r <= S_LOOKUP;
      fill_cnt_r <= '0;
      for (int i = 0; i < sets_p; i++) begin
        rr_r[i] <= '0;
      end
    end else begin
      live_r <= 1'b1;
      if (ready_o) begin
        tl_v_r <= v_i;
      end
      if (v_we_o) begin
        tv_v_r <= 1'b1;
        state_r <= S_LOOKUP;
      end else begin
        if (v_o && yumi_i) begin
          tv_v_r <= 1'b0;
        end
        case (state_r)
          S_LOOKUP: begin
            if (go_miss) begin
              fill_cnt_r <= '0;
              state_r <= (valid_r[tv_set][victim] && dirty_r[tv_set][victim]) ? S_WB : S_FILL;
            end else if (op_fire) begin
              state_r <= S_DONE;
            end
          end
          S_WB: state_r <= S_FILL;
          S_FILL: begin
            fill_cnt_r <= fill_cnt_r + 1'b1;
            if (fill_last) begin
              // refill done, the retried lookup hits
              rr_r[tv_set] <= (victim == lg_ways_lp'(ways_p - 1)) ? '0 : victim + 1'b1;
              state_r <= S_LOOKUP;
            end
          end
          default: ;
        endcase
      end
    end
  end

endmodule

/* link_cache_pkg.sv */
package link_cache_pkg;

  localparam int addr_width_gp = 12;
  localparam int data_width_gp = 32;
  localparam int cord_width_gp = 4;
  localparam int reg_id_width_gp = 5;

  typedef enum logic [2:0] {
    e_remote_load,
    e_remote_store,
    e_remote_amoswap,
    e_remote_amoor,
    e_cache_op
  } packet_op_e;

  typedef struct packed {
    logic icache_fetch;
    logic float_wb;
    logic is_byte_op;
    logic is_hex_op;
    logic is_unsigned_op;
    logic [1:0] part_sel;
  } load_info_s;

  typedef struct packed {
    logic [data_width_gp-$bits(load_info_s)-1:0] pad;
    load_info_s load_info;
  } load_info_pad_s;

  // store data and load flags share the payload word
  typedef union packed {
    logic [data_width_gp-1:0] data;
    load_info_pad_s load_info_s;
  } payload_u;

  typedef enum logic [1:0] {
    e_afl,
    e_aflinv,
    e_ainv
  } cache_op_e;

  typedef struct packed {
    logic pad;
    logic [3:0] mask;
  } store_mask_s;

  typedef struct packed {
    logic [2:0] pad;
    cache_op_e cache_op;
  } cache_op_s;

  typedef union packed {
    logic [reg_id_width_gp-1:0] reg_id;
    store_mask_s store_mask;
    cache_op_s cache_op_s;
  } reg_id_u;

  typedef struct packed {
    packet_op_e op;
    logic [addr_width_gp-1:0] addr;
    payload_u payload;
    reg_id_u reg_id;
    logic [cord_width_gp-1:0] src_y_cord;
    logic [cord_width_gp-1:0] src_x_cord;
  } link_packet_s;

  typedef enum logic [1:0] {
    e_return_credit,
    e_return_int_wb,
    e_return_float_wb,
    e_return_ifetch
  } return_type_e;

  typedef struct packed {
    return_type_e pkt_type;
    logic [data_width_gp-1:0] data;
    logic [reg_id_width_gp-1:0] reg_id;
    logic [cord_width_gp-1:0] y_cord;
    logic [cord_width_gp-1:0] x_cord;
  } return_packet_s;

  typedef enum logic [3:0] {
    TAGST, TAGLA, TAGFL,
    SM, LW, LH, LHU, LB, LBU,
    AMOSWAP_W, AMOOR_W,
    AFL, AFLINV, AINV
  } cache_opcode_e;

  // byte address with the tag-space bit already stripped
  typedef struct packed {
    cache_opcode_e opcode;
    logic [addr_width_gp:0] addr;
    logic [data_width_gp-1:0] data;
    logic [data_width_gp/8-1:0] mask;
  } cache_pkt_s;

endpackage

/* link_cache_top.sv */
`timescale 1ns/1ns

module link_cache_top #(
  parameter int sets_p = 8,
  parameter int ways_p = 2,
  parameter int block_words_p = 4,
  parameter int fifo_els_p = 4,
  parameter int mem_words_p = 1024
) (
  input  logic clk_i,
  input  logic reset_i,
  input  link_cache_pkg::link_packet_s req_i,
  input  logic req_v_i,
  output logic req_ready_o,
  output link_cache_pkg::return_packet_s ret_o,
  output logic ret_v_o,
  input  logic ret_yumi_i
);

  import link_cache_pkg::*;

  link_packet_s packet;
  logic packet_v, packet_yumi;
  return_packet_s return_packet;
  logic return_packet_v, return_packet_ready;
  cache_pkt_s cache_pkt;
  logic cache_v, cache_ready;
  logic [data_width_gp-1:0] cache_data;
  logic cache_data_v, cache_yumi, cache_v_we;

  link_endpoint #(
    .fifo_els_p(fifo_els_p)
  ) i_link_endpoint (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .req_i(req_i),
    .req_v_i(req_v_i),
    .req_ready_o(req_ready_o),
    .packet_o(packet),
    .packet_v_o(packet_v),
    .packet_yumi_i(packet_yumi),
    .return_packet_i(return_packet),
    .return_packet_v_i(return_packet_v),
    .return_packet_ready_o(return_packet_ready),
    .ret_o(ret_o),
    .ret_v_o(ret_v_o),
    .ret_yumi_i(ret_yumi_i)
  );

  link_to_cache #(
    .sets_p(sets_p),
    .ways_p(ways_p),
    .block_words_p(block_words_p)
  ) i_link_to_cache (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .packet_i(packet),
    .packet_v_i(packet_v),
    .packet_yumi_o(packet_yumi),
    .return_packet_o(return_packet),
    .return_packet_v_o(return_packet_v),
    .return_packet_ready_i(return_packet_ready),
    .cache_pkt_o(cache_pkt),
    .cache_v_o(cache_v),
    .cache_ready_i(cache_ready),
    .cache_data_i(cache_data),
    .cache_v_i(cache_data_v),
    .cache_yumi_o(cache_yumi),
    .cache_v_we_i(cache_v_we)
  );

  cache_core #(
    .sets_p(sets_p),
    .ways_p(ways_p),
    .block_words_p(block_words_p),
    .mem_words_p(mem_words_p)
  ) i_cache_core (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .pkt_i(cache_pkt),
    .v_i(cache_v),
    .ready_o(cache_ready),
    .data_o(cache_data),
    .v_o(cache_data_v),
    .yumi_i(cache_yumi),
    .v_we_o(cache_v_we)
  );

endmodule

/* link_endpoint.sv */
`timescale 1ns/1ns

module link_endpoint #(
  parameter int fifo_els_p = 4
) (
  input  logic clk_i,
  input  logic reset_i,

  // network side
  input  link_cache_pkg::link_packet_s req_i,
  input  logic req_v_i,
  output logic req_ready_o,

  // bridge side
  output link_cache_pkg::link_packet_s packet_o,
  output logic packet_v_o,
  input  logic packet_yumi_i,

  input  link_cache_pkg::return_packet_s return_packet_i,
  input  logic return_packet_v_i,
  output logic return_packet_ready_o,

  // network side replies
  output link_cache_pkg::return_packet_s ret_o,
  output logic ret_v_o,
  input  logic ret_yumi_i
);

  import link_cache_pkg::*;

  // incoming requests
  link_fifo #(
    .width_p($bits(link_packet_s)),
    .els_p(fifo_els_p)
  ) i_req_fifo (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .data_i(req_i),
    .v_i(req_v_i),
    .ready_o(req_ready_o),
    .data_o(packet_o),
    .v_o(packet_v_o),
    .yumi_i(packet_yumi_i)
  );

  // outgoing replies
  link_fifo #(
    .width_p($bits(return_packet_s)),
    .els_p(fifo_els_p)
  ) i_ret_fifo (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .data_i(return_packet_i),
    .v_i(return_packet_v_i),
    .ready_o(return_packet_ready_o),
    .data_o(ret_o),
    .v_o(ret_v_o),
    .yumi_i(ret_yumi_i)
  );

endmodule

/* link_fifo.sv */
`timescale 1ns/1ns

module link_fifo #(
  parameter int width_p = 8,
  parameter int els_p = 4
) (
  input  logic clk_i,
  input  logic reset_i,
  input  logic [width_p-1:0] data_i,
  input  logic v_i,
  output logic ready_o,
  output logic [width_p-1:0] data_o,
  output logic v_o,
  input  logic yumi_i
);

  localparam int ptr_width_lp = (els_p > 1) ? $clog2(els_p) : 1;

  logic [width_p-1:0] mem_r [els_p];
  logic [ptr_width_lp-1:0] rptr_r, wptr_r, rptr_n, wptr_n;
  logic full_r, empty_r;
  logic enq, deq;

  assign ready_o = ~full_r;
  assign v_o = ~empty_r;
  assign data_o = mem_r[rptr_r];
  assign enq = v_i & ~full_r;
  assign deq = yumi_i;

  // pointers wrap at els_p so any depth works
  assign rptr_n = (rptr_r == ptr_width_lp'(els_p - 1)) ? '0 : rptr_r + 1'b1;
  assign wptr_n = (wptr_r == ptr_width_lp'(els_p - 1)) ? '0 : wptr_r + 1'b1;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rptr_r <= '0;
      wptr_r <= '0;
      full_r <= 1'b0;
      empty_r <= 1'b1;
    end else begin
      if (enq) begin
        wptr_r <= wptr_n;
      end
      if (deq) begin
        rptr_r <= rptr_n;
      end
      if (enq && !deq) begin
        empty_r <= 1'b0;
        full_r <= (wptr_n == rptr_r);
      end else if (deq && !enq) begin
        full_r <= 1'b0;
        empty_r <= (rptr_n == wptr_r);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_r[wptr_r] <= data_i;
    end
  end

endmodule

/* link_to_cache.sv */
`timescale 1ns/1ns

module link_to_cache #(
  parameter int sets_p = 8,
  parameter int ways_p = 2,
  parameter int block_words_p = 4
) (
  input  logic clk_i,
  input  logic reset_i,

  input  link_cache_pkg::link_packet_s packet_i,
  input  logic packet_v_i,
  output logic packet_yumi_o,

  output link_cache_pkg::return_packet_s return_packet_o,
  output logic return_packet_v_o,
  input  logic return_packet_ready_i,

  output link_cache_pkg::cache_pkt_s cache_pkt_o,
  output logic cache_v_o,
  input  logic cache_ready_i,

  input  logic [link_cache_pkg::data_width_gp-1:0] cache_data_i,
  input  logic cache_v_i,
  output logic cache_yumi_o,

  input  logic cache_v_we_i
);

  import link_cache_pkg::*;

  localparam int lg_sets_lp = (sets_p > 1) ? $clog2(sets_p) : 1;
  localparam int lg_ways_lp = (ways_p > 1) ? $clog2(ways_p) : 1;
  localparam int lg_words_lp = (block_words_p > 1) ? $clog2(block_words_p) : 1;
  localparam int block_off_lp = lg_words_lp + 2;
  localparam int cnt_width_lp = lg_sets_lp + lg_ways_lp + 1;
  localparam int total_lp = sets_p * ways_p;

  typedef enum logic [1:0] {RESET, CLEAR_TAG, READY} state_e;

  typedef struct packed {
    return_type_e pkt_type;
    logic [reg_id_width_gp-1:0] reg_id;
    logic [cord_width_gp-1:0] y_cord;
    logic [cord_width_gp-1:0] x_cord;
  } info_s;

  state_e state_r, state_n;
  logic [cnt_width_lp-1:0] sent_r, sent_n, recv_r, recv_n;
  info_s tl_info_r, tv_info_r;
  load_info_s load_info;
  return_type_e ret_type;
  cache_opcode_e req_opcode;
  logic [reg_id_width_gp-1:0] payload_hash;
  logic is_load, credit_only;

  assign load_info = packet_i.payload.load_info_s.load_info;
  assign is_load = (packet_i.op == e_remote_load);
  assign credit_only = (packet_i.op == e_remote_store) || (packet_i.op == e_cache_op);

  assign payload_hash = packet_i.payload.data[4:0] ^ packet_i.payload.data[12:8]
                      ^ packet_i.payload.data[20:16] ^ packet_i.payload.data[28:24];

  always_comb begin
    if (credit_only) begin
      ret_type = e_return_credit;
    end else if (is_load && load_info.icache_fetch) begin
      ret_type = e_return_ifetch;
    end else if (is_load && load_info.float_wb) begin
      ret_type = e_return_float_wb;
    end else begin
      ret_type = e_return_int_wb;
    end
  end

  // msb of the word address selects tag space
  always_comb begin
    req_opcode = LW;
    if (packet_i.addr[addr_width_gp-1]) begin
      case (packet_i.op)
        e_remote_store: req_opcode = TAGST;
        e_cache_op:     req_opcode = TAGFL;
        default:        req_opcode = TAGLA;
      endcase
    end else begin
      case (packet_i.op)
        e_remote_store:   req_opcode = SM;
        e_remote_amoswap: req_opcode = AMOSWAP_W;
        e_remote_amoor:   req_opcode = AMOOR_W;
        e_cache_op: begin
          case (packet_i.reg_id.cache_op_s.cache_op)
            e_afl:    req_opcode = AFL;
            e_aflinv: req_opcode = AFLINV;
            default:  req_opcode = AINV;
          endcase
        end
        default: begin
          if (load_info.is_byte_op) begin
            req_opcode = load_info.is_unsigned_op ? LBU : LB;
          end else if (load_info.is_hex_op) begin
            req_opcode = load_info.is_unsigned_op ? LHU : LH;
          end
        end
      endcase
    end
  end

  always_comb begin
    state_n = state_r;
    sent_n = sent_r;
    recv_n = recv_r;
    cache_pkt_o = '{opcode: TAGST, addr: '0, data: '0, mask: '0};
    cache_v_o = 1'b0;
    cache_yumi_o = 1'b0;
    packet_yumi_o = 1'b0;
    return_packet_v_o = 1'b0;
    case (state_r)
      RESET: state_n = CLEAR_TAG;
      CLEAR_TAG: begin
        // low counter bits walk the sets, upper bits the ways
        cache_v_o = (sent_r != cnt_width_lp'(total_lp));
        cache_pkt_o.addr = (addr_width_gp + 1)'(
          {sent_r[lg_sets_lp+lg_ways_lp-1:0], block_off_lp'(0)});
        if (cache_v_o && cache_ready_i) begin
          sent_n = sent_r + 1'b1;
        end
        if (cache_v_i) begin
          recv_n = recv_r + 1'b1;
        end
        cache_yumi_o = cache_v_i;
        if (sent_r == cnt_width_lp'(total_lp) && recv_r == cnt_width_lp'(total_lp)) begin
          state_n = READY;
        end
      end
      READY: begin
        cache_v_o = packet_v_i;
        packet_yumi_o = packet_v_i & cache_ready_i;
        cache_pkt_o.opcode = req_opcode;
        cache_pkt_o.data = packet_i.payload.data;
        cache_pkt_o.mask = packet_i.reg_id.store_mask.mask;
        cache_pkt_o.addr = {packet_i.addr[addr_width_gp-2:0],
                            is_load ? load_info.part_sel : 2'b00};
        return_packet_v_o = cache_v_i;
        cache_yumi_o = cache_v_i & return_packet_ready_i;
      end
      default: state_n = READY;
    endcase
  end

  // follows the request through tl and tv of the cache
  always_ff @(posedge clk_i) begin
    if (state_r == READY) begin
      if (cache_v_o && cache_ready_i) begin
        tl_info_r <= '{
          pkt_type: ret_type,
          reg_id:   credit_only ? payload_hash : packet_i.reg_id.reg_id,
          y_cord:   packet_i.src_y_cord,
          x_cord:   packet_i.src_x_cord
        };
      end
      if (cache_v_we_i) begin
        tv_info_r <= tl_info_r;
      end
    end
  end

  assign return_packet_o = '{
    pkt_type: tv_info_r.pkt_type,
    data:     cache_data_i,
    reg_id:   tv_info_r.reg_id,
    y_cord:   tv_info_r.y_cord,
    x_cord:   tv_info_r.x_cord
  };

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= RESET;
      sent_r <= '0;
      recv_r <= '0;
    end else begin
      state_r <= state_n;
      sent_r <= sent_n;
      recv_r <= recv_n;
    end
  end

endmodule

/* run.sh */
#!/bin/bash
# compile with Verilator, run, and judge the result from the log

rm -f sim.log

verilator --binary --timing -f verilog.f --top-module tb_link_cache_top -o sim \
  && ./obj_dir/sim 2>&1 | tee sim.log

grep -q "^Everything OK$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* tb_link_cache_top.sv */
`timescale 1ns/1ns

module tb_link_cache_top;

  import link_cache_pkg::*;

  localparam int sets_p = 8;
  localparam int ways_p = 2;
  localparam int block_words_p = 4;
  localparam int fifo_els_p = 4;
  localparam int mem_words_p = 1024;

  localparam int lg_sets_lp = $clog2(sets_p);
  localparam int lg_words_lp = $clog2(block_words_p);
  localparam int tag_width_lp = addr_width_gp + 1 - (lg_words_lp + 2) - lg_sets_lp;
  localparam logic [31:0] tag_mask_lp = 32'((1 << tag_width_lp) - 1);
  localparam int timeout_lp = 500;

  logic clk_i = 1'b0;
  logic reset_i;
  link_packet_s req_i;
  logic req_v_i;
  logic req_ready_o;
  return_packet_s ret_o;
  logic ret_v_o;
  logic ret_yumi_i;

  logic [31:0] ref_mem [mem_words_p];
  // only what was written through tag space
  logic [31:0] tag_tbl [sets_p][ways_p];
  return_packet_s exp_q [$];

  link_cache_top #(
    .sets_p(sets_p),
    .ways_p(ways_p),
    .block_words_p(block_words_p),
    .fifo_els_p(fifo_els_p),
    .mem_words_p(mem_words_p)
  ) i_link_cache_top (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .req_i(req_i),
    .req_v_i(req_v_i),
    .req_ready_o(req_ready_o),
    .ret_o(ret_o),
    .ret_v_o(ret_v_o),
    .ret_yumi_i(ret_yumi_i)
  );

  always #20 clk_i = ~clk_i;

  task automatic fail_stop();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
      fail_stop();
    end
  endtask

  function automatic logic [11:0] data_addr(input int tag, input int set, input int word);
    return 12'((tag << (lg_sets_lp + lg_words_lp)) | (set << lg_words_lp) | word);
  endfunction

  function automatic logic [11:0] tag_addr(input int set, input int way);
    return 12'(2048 | (way << (lg_sets_lp + lg_words_lp)) | (set << lg_words_lp));
  endfunction

  // icache, float, byte, half, unsigned, part select
  function automatic logic [31:0] load_flags(input logic icache, input logic fwb,
                                             input logic is_byte, input logic is_half,
                                             input logic uns, input logic [1:0] ps);
    return {25'b0, icache, fwb, is_byte, is_half, uns, ps};
  endfunction

  function automatic link_packet_s make_pkt(input packet_op_e op, input logic [11:0] addr,
                                            input logic [31:0] data, input logic [4:0] rid);
    link_packet_s p;
    p.op = op;
    p.addr = addr;
    p.payload.data = data;
    p.reg_id.reg_id = rid;
    p.src_y_cord = 4'($urandom_range(15, 0));
    p.src_x_cord = 4'($urandom_range(15, 0));
    return p;
  endfunction

  // expected reply plus its effect on memory and tags
  function automatic return_packet_s model(input link_packet_s p);
    return_packet_s r;
    logic [31:0] d;
    logic [31:0] w;
    logic [7:0] b;
    logic [15:0] h;
    int a;
    int s;
    int wy;
    int ps;
    int i;
    d = p.payload.data;
    a = int'(p.addr[9:0]);
    ps = int'(d[1:0]);
    r.y_cord = p.src_y_cord;
    r.x_cord = p.src_x_cord;
    r.data = '0;
    r.reg_id = p.reg_id.reg_id;
    r.pkt_type = e_return_int_wb;
    if (p.op == e_remote_store || p.op == e_cache_op) begin
      r.pkt_type = e_return_credit;
      r.reg_id = d[4:0] ^ d[12:8] ^ d[20:16] ^ d[28:24];
    end else if (p.op == e_remote_load && d[6]) begin
      r.pkt_type = e_return_ifetch;
    end else if (p.op == e_remote_load && d[5]) begin
      r.pkt_type = e_return_float_wb;
    end
    if (p.addr[11]) begin
      s = (int'(p.addr) >> lg_words_lp) % sets_p;
      wy = (int'(p.addr) >> (lg_words_lp + lg_sets_lp)) % ways_p;
      if (p.op == e_remote_store) begin
        tag_tbl[s][wy] = (d & tag_mask_lp) | (d & 32'h8000_0000);
      end else if (p.op != e_cache_op) begin
        r.data = tag_tbl[s][wy];
      end
    end else begin
      w = ref_mem[a];
      case (p.op)
        e_remote_store: begin
          for (i = 0; i < 4; i++) begin
            if (p.reg_id.store_mask.mask[i]) begin
              w[8*i +: 8] = d[8*i +: 8];
            end
          end
          ref_mem[a] = w;
        end
        e_remote_load: begin
          b = w[8*ps +: 8];
          h = ps[1] ? w[31:16] : w[15:0];
          if (d[4]) begin
            r.data = d[2] ? {24'b0, b} : {{24{b[7]}}, b};
          end else if (d[3]) begin
            r.data = d[2] ? {16'b0, h} : {{16{h[15]}}, h};
          end else begin
            r.data = w;
          end
        end
        e_remote_amoswap: begin
          r.data = w;
          ref_mem[a] = d;
        end
        e_remote_amoor: begin
          r.data = w;
          ref_mem[a] = w | d;
        end
        default: ;
      endcase
    end
    return r;
  endfunction

  task automatic send_req(input link_packet_s p);
    int cycles;
    cycles = 0;
    exp_q.push_back(model(p));
    req_i = p;
    req_v_i = 1'b1;
    while (!req_ready_o) begin
      @(posedge clk_i);
      #2;
      cycles++;
      if (cycles > timeout_lp) begin
        $display("timeout: request not accepted after %0d cycles", cycles);
        fail_stop();
      end
    end
    @(posedge clk_i);
    #2;
    req_v_i = 1'b0;
  endtask

  task automatic get_ret();
    int cycles;
    return_packet_s e;
    cycles = 0;
    while (!ret_v_o) begin
      @(posedge clk_i);
      #2;
      cycles++;
      if (cycles > timeout_lp) begin
        $display("timeout: no reply on ret_o after %0d cycles", cycles);
        fail_stop();
      end
    end
    if (exp_q.size() == 0) begin
      $display("a reply arrived with no request outstanding");
      fail_stop();
    end
    e = exp_q.pop_front();
    check("ret_o.pkt_type", 32'(ret_o.pkt_type), 32'(e.pkt_type));
    check("ret_o.data", ret_o.data, e.data);
    check("ret_o.reg_id", 32'(ret_o.reg_id), 32'(e.reg_id));
    check("ret_o.y_cord", 32'(ret_o.y_cord), 32'(e.y_cord));
    check("ret_o.x_cord", 32'(ret_o.x_cord), 32'(e.x_cord));
    ret_yumi_i = 1'b1;
    @(posedge clk_i);
    #2;
    ret_yumi_i = 1'b0;
  endtask

  task automatic transact(input link_packet_s p);
    send_req(p);
    get_ret();
  endtask

  // tags must read as cleared before anything else is served
  task automatic tags_after_reset();
    for (int s = 0; s < sets_p; s++) begin
      for (int w = 0; w < ways_p; w++) begin
        transact(make_pkt(e_remote_load, tag_addr(s, w), '0, 5'($urandom_range(31, 0))));
      end
    end
  endtask

  task automatic store_load_conflicts();
    logic [11:0] addrs [24];
    for (int i = 0; i < 24; i++) begin
      addrs[i] = data_addr($urandom_range(4, 0), (i % 2) ? 3 : 5, $urandom_range(3, 0));
      transact(make_pkt(e_remote_store, addrs[i], $urandom(), 5'($urandom_range(31, 0))));
    end
    for (int i = 23; i >= 0; i--) begin
      transact(make_pkt(e_remote_load, addrs[i], '0, 5'($urandom_range(31, 0))));
    end
  endtask

  task automatic sub_word_loads();
    logic [11:0] a;
    logic [1:0] rt;
    a = data_addr(6, 1, 2);
    transact(make_pkt(e_remote_store, a, 32'h7E91_80F3, 5'h0F));
    for (int ps = 0; ps < 4; ps++) begin
      for (int k = 0; k < 4; k++) begin
        // cycle through all return type flag pairs
        rt = 2'(ps + k);
        transact(make_pkt(e_remote_load, a,
                          load_flags(rt[1], rt[0], k < 2, k >= 2, k[0], 2'(ps)),
                          5'($urandom_range(31, 0))));
      end
    end
  endtask

  task automatic atomic_ops();
    logic [11:0] a;
    for (int i = 0; i < 4; i++) begin
      a = data_addr($urandom_range(7, 0), $urandom_range(7, 0), $urandom_range(3, 0));
      transact(make_pkt(e_remote_amoswap, a, $urandom(), 5'($urandom_range(31, 0))));
      transact(make_pkt(e_remote_load, a, '0, 5'($urandom_range(31, 0))));
      transact(make_pkt(e_remote_amoor, a, $urandom(), 5'($urandom_range(31, 0))));
      transact(make_pkt(e_remote_load, a, '0, 5'($urandom_range(31, 0))));
    end
  endtask

  task automatic maintenance_ops();
    logic [11:0] a;
    a = data_addr(2, 6, 1);
    transact(make_pkt(e_remote_store, a, $urandom(), 5'h0F));
    transact(make_pkt(e_cache_op, a, $urandom(), {3'b000, e_afl}));
    transact(make_pkt(e_remote_load, a, '0, 5'd3));
    // dirty again so that the flush in aflinv has to write back
    transact(make_pkt(e_remote_store, a, $urandom(), 5'h0F));
    transact(make_pkt(e_cache_op, a, $urandom(), {3'b000, e_aflinv}));
    transact(make_pkt(e_remote_load, a, '0, 5'd4));
    // block is clean here, so dropping it loses nothing
    transact(make_pkt(e_cache_op, a, $urandom(), {3'b000, e_ainv}));
    transact(make_pkt(e_remote_load, a, '0, 5'd5));
    // flush way 1 of set 6 before overwriting its tag
    transact(make_pkt(e_cache_op, tag_addr(6, 1), $urandom(), 5'd0));
    transact(make_pkt(e_remote_store, tag_addr(6, 1), 32'h8000_002A, 5'd0));
    transact(make_pkt(e_remote_load, tag_addr(6, 1), '0, 5'd9));
    transact(make_pkt(e_remote_store, tag_addr(6, 1), 32'h0000_0000, 5'd0));
    transact(make_pkt(e_remote_load, tag_addr(6, 1), '0, 5'd10));
    transact(make_pkt(e_remote_load, a, '0, 5'd11));
  endtask

  task automatic stalled_returns();
    int n;
    int sel;
    logic [11:0] a;
    link_packet_s p;
    n = 16;
    fork
      begin
        for (int i = 0; i < n; i++) begin
          sel = $urandom_range(2, 0);
          a = data_addr($urandom_range(3, 0), 2, $urandom_range(3, 0));
          if (sel == 0) begin
            p = make_pkt(e_remote_store, a, $urandom(), 5'($urandom_range(31, 0)));
          end else if (sel == 1) begin
            p = make_pkt(e_remote_load, a, 32'($urandom_range(127, 0)),
                         5'($urandom_range(31, 0)));
          end else begin
            p = make_pkt(e_remote_amoor, a, $urandom(), 5'($urandom_range(31, 0)));
          end
          send_req(p);
        end
      end
      begin
        repeat ($urandom_range(40, 10)) begin
          @(posedge clk_i);
          #2;
        end
        for (int i = 0; i < n; i++) begin
          repeat ($urandom_range(3, 0)) begin
            @(posedge clk_i);
            #2;
          end
          get_ret();
        end
      end
    join
    repeat (8) begin
      @(posedge clk_i);
      #2;
      check("ret_v_o", 32'(ret_v_o), 32'd0);
    end
  endtask

  // two items in the cache and both FIFOs full leave no room for one more
  task automatic full_request_fifo();
    int depth;
    logic [11:0] a;
    depth = 2 * fifo_els_p + 2;
    for (int i = 0; i < depth; i++) begin
      a = data_addr($urandom_range(3, 0), 4, $urandom_range(3, 0));
      send_req(make_pkt(e_remote_load, a, '0, 5'($urandom_range(31, 0))));
    end
    repeat (4) begin
      check("req_ready_o", 32'(req_ready_o), 32'd0);
      @(posedge clk_i);
      #2;
    end
    for (int i = 0; i < depth; i++) begin
      get_ret();
    end
  endtask

  initial begin
    void'($urandom(12867));
    reset_i = 1'b1;
    req_i = '0;
    req_v_i = 1'b0;
    ret_yumi_i = 1'b0;
    for (int i = 0; i < mem_words_p; i++) begin
      ref_mem[i] = '0;
    end
    for (int s = 0; s < sets_p; s++) begin
      for (int w = 0; w < ways_p; w++) begin
        tag_tbl[s][w] = '0;
      end
    end
    repeat (8) @(posedge clk_i);
    #2;
    reset_i = 1'b0;

    tags_after_reset();
    store_load_conflicts();
    sub_word_loads();
    atomic_ops();
    maintenance_ops();
    stalled_returns();
    full_request_fifo();

    $display("Everything OK");
    $finish;
  end

endmodule

/* verilog.f */
link_cache_pkg.sv
link_fifo.sv
link_endpoint.sv
link_to_cache.sv
cache_core.sv
link_cache_top.sv
tb_link_cache_top.sv
